/* decoder_reg_program.sv */
//##########################################################################
// steps through the decoder setup table, one serial write per entry
// restarts from the first entry on a falling rts0
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module decoder_reg_program (
   input  wire logic             tm3_clk_v0,
   input  wire logic             rst,
   input  wire logic             rts0,
   input  wire logic             busy,
   output vidin_pkg::iic_write_t wr,
   output logic                  start,
   output logic                  done
);

   vidin_pkg::prog_state_e state;
   logic [3:0]             idx;
   logic [2:0]             rts_sync;
   logic                   rts_fall;

   assign rts_fall = !rts_sync[1] && rts_sync[2];
   assign done     = (state == vidin_pkg::PROG_DONE);

   // decoder setup, subaddress then value
   always_comb
   begin
      case (idx)
         4'd0:    wr = '{subaddr: 8'h02, data: 8'hC0};
         4'd1:    wr = '{subaddr: 8'h03, data: 8'h23};
         4'd2:    wr = '{subaddr: 8'h06, data: 8'hEB};
         4'd3:    wr = '{subaddr: 8'h07, data: 8'hE0};
         4'd4:    wr = '{subaddr: 8'h08, data: 8'h80};
         4'd5:    wr = '{subaddr: 8'h09, data: 8'h01};
         4'd6:    wr = '{subaddr: 8'h0A, data: 8'h80};
         4'd7:    wr = '{subaddr: 8'h0B, data: 8'h47};
         4'd8:    wr = '{subaddr: 8'h0C, data: 8'h40};
         4'd9:    wr = '{subaddr: 8'h0E, data: 8'h01};
         4'd10:   wr = '{subaddr: 8'h10, data: 8'h00};
         4'd11:   wr = '{subaddr: 8'h11, data: 8'h1C};
         default: wr = '{subaddr: 8'h12, data: 8'h09};
      endcase
   end

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         state    <= vidin_pkg::PROG_START;
         idx      <= '0;
         start    <= 1'b0;
         rts_sync <= '0;
      end
      else
      begin
         rts_sync <= {rts_sync[1:0], rts0};
         start    <= 1'b0;
         if (rts_fall)
         begin
            state <= vidin_pkg::PROG_START;
            idx   <= '0;
         end
         else
         begin
            case (state)
               vidin_pkg::PROG_START:
               begin
                  // a frame still in flight finishes first
                  if (!busy)
                  begin
                     start <= 1'b1;
                     state <= vidin_pkg::PROG_WAIT;
                  end
               end
               vidin_pkg::PROG_WAIT:
               begin
                  if (busy)
                     state <= vidin_pkg::PROG_NEXT;
               end
               vidin_pkg::PROG_NEXT:
               begin
                  if (!busy && (idx == 4'(`VIDIN_REG_COUNT - 1)))
                     state <= vidin_pkg::PROG_DONE;
                  else if (!busy)
                  begin
                     idx   <= idx + 1'b1;
                     state <= vidin_pkg::PROG_START;
                  end
               end
               default:
               begin
                  state <= vidin_pkg::PROG_DONE;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
vidin_pkg.sv
vidin_capture.sv
vidin_pixel_out.sv
iic_write_serializer.sv
decoder_reg_program.sv
vidin_top.sv
vidin_props.sv
vidin_checker.sv
tb_vidin.sv

/* iic_write_serializer.sv */
//##########################################################################
// shifts one decoder register write out on the scl/sda pair
// start pulse loads a frame, busy stays high until the stop condition ends
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module iic_write_serializer (
   input  wire logic                   tm3_clk_v0,
   input  wire logic                   rst,
   input  wire vidin_pkg::iic_write_t  wr,
   input  wire logic                   start,
   output logic                        busy,
   output logic                        scl,
   output logic                        sda
);

   localparam int DIV_W = $clog2(`VIDIN_IIC_DIV);
   // three bytes, each followed by an ack slot
   localparam int FRAME_W = 3 * 9;

   vidin_pkg::iic_phase_e phase;
   logic [DIV_W-1:0]      div_cnt;
   logic [4:0]            bit_cnt;
   logic [1:0]            sub_cnt;
   logic [FRAME_W-1:0]    shreg;
   logic                  step;

   assign step = (div_cnt == DIV_W'(`VIDIN_IIC_DIV - 1));
   assign busy = (phase != vidin_pkg::IIC_IDLE);

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         phase   <= vidin_pkg::IIC_IDLE;
         div_cnt <= '0;
         bit_cnt <= '0;
         sub_cnt <= '0;
      end
      else
      begin
         if ((phase == vidin_pkg::IIC_IDLE) || step)
            div_cnt <= '0;
         else
            div_cnt <= div_cnt + 1'b1;
         case (phase)
            vidin_pkg::IIC_IDLE:
            begin
               if (start)
                  phase <= vidin_pkg::IIC_START;
            end
            vidin_pkg::IIC_START:
            begin
               if (step)
               begin
                  phase   <= vidin_pkg::IIC_BIT;
                  bit_cnt <= '0;
                  sub_cnt <= '0;
               end
            end
            vidin_pkg::IIC_BIT:
            begin
               // each bit is scl low, high, low
               if (step && (sub_cnt == 2'd2))
               begin
                  sub_cnt <= '0;
                  if (bit_cnt == 5'(FRAME_W - 1))
                     phase <= vidin_pkg::IIC_STOP;
                  else
                     bit_cnt <= bit_cnt + 1'b1;
               end
               else if (step)
                  sub_cnt <= sub_cnt + 1'b1;
            end
            default:
            begin
               if (step && (sub_cnt == 2'd1))
                  phase <= vidin_pkg::IIC_IDLE;
               else if (step)
                  sub_cnt <= sub_cnt + 1'b1;
            end
         endcase
      end
   end

   // frame bits, msb first, ack slots driven low
   always_ff @(posedge tm3_clk_v0)
   begin
      if ((phase == vidin_pkg::IIC_IDLE) && start)
         shreg <= {`VIDIN_IIC_DEV_ADDR, 1'b0, wr.subaddr, 1'b0, wr.data, 1'b0};
      else if ((phase == vidin_pkg::IIC_BIT) && step && (sub_cnt == 2'd2))
         shreg <= {shreg[FRAME_W-2:0], 1'b0};
   end

   always_comb
   begin
      case (phase)
         vidin_pkg::IIC_START:
         begin
            scl = 1'b1;
            sda = 1'b0;
         end
         vidin_pkg::IIC_BIT:
         begin
            scl = (sub_cnt == 2'd1);
            sda = shreg[FRAME_W-1];
         end
         vidin_pkg::IIC_STOP:
         begin
            // sda rises in the second stop step with scl high
            scl = 1'b1;
            sda = (sub_cnt == 2'd1);
         end
         default:
         begin
            scl = 1'b1;
            sda = 1'b1;
         end
      endcase
   end

endmodule

`default_nettype wire

/* tb_vidin.sv */
//##########################################################################
// testbench top for the video front end
// plays the S runs of vidin_input.txt into the DUT, the checker compares
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module tb_vidin;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD = 40;
   localparam int PRE_LINE = 2;

   logic                     tm3_clk_v0;
   logic                     rst;
   logic                     vs;
   logic                     href;
   logic                     cref;
   logic                     rts0;
   logic [`VIDIN_VPO_W-1:0]  vpo;
   wire logic                sda;
   wire logic                scl;
   wire logic                new_data;
   wire logic [`VIDIN_PIX_W-1:0]  rgb;
   wire logic [`VIDIN_ADDR_W-1:0] addr;
   wire logic                reg_prog_done;
   wire logic                finished;
   int                       tests_run;
   int                       tests_failed;
   int                       error_count;

   vidin_pkg::video_in_t run_smp [$];
   int                   run_cnt [$];
   bit                   run_pair [$];
   longint               limit_ns;
   bit                   limit_ready;

   vidin_top DUT (
      .tm3_clk_v0     (tm3_clk_v0),
      .rst            (rst),
      .tm3_vidin_vs   (vs),
      .tm3_vidin_href (href),
      .tm3_vidin_cref (cref),
      .tm3_vidin_rts0 (rts0),
      .tm3_vidin_vpo  (vpo),
      .tm3_vidin_sda  (sda),
      .tm3_vidin_scl  (scl),
      .vidin_new_data (new_data),
      .vidin_rgb_reg  (rgb),
      .vidin_addr_reg (addr),
      .reg_prog_done  (reg_prog_done)
   );

   vidin_checker u_checker (
      .tm3_clk_v0    (tm3_clk_v0),
      .rst           (rst),
      .scl           (scl),
      .sda           (sda),
      .new_data      (new_data),
      .rgb           (rgb),
      .addr          (addr),
      .reg_prog_done (reg_prog_done),
      .finished      (finished),
      .tests_run     (tests_run),
      .tests_failed  (tests_failed),
      .error_count   (error_count)
   );

   initial
   begin
      tm3_clk_v0 = 1'b0;
      forever #(PERIOD / 2) tm3_clk_v0 = ~tm3_clk_v0;
   end

   // returns the number of clock cycles the runs take
   function automatic longint load_stimulus();
      int    fd;
      int    f_vs, f_href, f_cref, f_rts0, f_cnt;
      logic [31:0] f_vpo;
      string line;
      longint cycles;
      cycles = 0;
      fd = $fopen("vidin_input.txt", "r");
      if (fd == 0)
         $display("cannot open vidin_input.txt, no stimulus is driven");
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 0 && line.getc(0) == "S" && $sscanf(line, "S %d %d %d %d %h %d",
                f_vs, f_href, f_cref, f_rts0, f_vpo, f_cnt) == 6)
            begin
               run_smp.push_back('{vs: f_vs[0], href: f_href[0], cref: f_cref[0],
                                   rts0: f_rts0[0], vpo: f_vpo[`VIDIN_VPO_W-1:0]});
               run_cnt.push_back(f_cnt);
               run_pair.push_back(f_cref == 2);
               cycles += (f_cref == 2) ? 2 * f_cnt : f_cnt;
            end
         end
         $fclose(fd);
      end
      return cycles;
   endfunction

   task automatic drive_sample(input vidin_pkg::video_in_t s);
      @(posedge tm3_clk_v0);
      vs   <= s.vs;
      href <= s.href;
      cref <= s.cref;
      rts0 <= s.rts0;
      vpo  <= s.vpo;
   endtask

   // a short active line with cref held low steps vert without a pixel
   task automatic advance_vert_count();
      vidin_pkg::video_in_t s;
      s = '{vs: 1'b0, href: 1'b1, cref: 1'b0, rts0: 1'b0, vpo: '0};
      repeat (PRE_LINE) drive_sample(s);
      s.href = 1'b0;
      drive_sample(s);
   endtask

   // pair runs give each pixel a high and a low cref sample
   task automatic play_run(input int i);
      vidin_pkg::video_in_t s;
      for (int n = 0; n < run_cnt[i]; n++)
      begin
         s = run_smp[i];
         if (run_pair[i])
         begin
            // odd pixels and field 1 are never emitted
            if (n[0] || s.rts0)
               s.vpo = `VIDIN_VPO_W'($urandom);
            s.cref = 1'b1;
            drive_sample(s);
            s.cref = 1'b0;
            drive_sample(s);
         end
         else
            drive_sample(s);
      end
   endtask

   initial
   begin
      longint cycles;
      void'($urandom(91360));
      rst  = 1'b0;
      vs   = 1'b0;
      href = 1'b0;
      cref = 1'b0;
      rts0 = 1'b0;
      vpo  = '0;
      cycles = load_stimulus();
      cycles += 8 + PRE_LINE + 1 + 2 * `VIDIN_REG_COUNT * 84 * `VIDIN_IIC_DIV;
      limit_ns = cycles * PERIOD;
      limit_ready = 1'b1;
      repeat (8) @(posedge tm3_clk_v0);
      rst <= 1'b1;
      advance_vert_count();
      for (int i = 0; i < run_cnt.size(); i++)
         play_run(i);
      wait (finished);
      @(posedge tm3_clk_v0);
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
      if ((error_count == 0) && (tests_failed == 0) && (tests_run == 6))
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      wait (limit_ready);
      #(limit_ns);
      $display("timeout after %0d ns, the expected pixels or register writes did not all appear",
               limit_ns);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* vidin_capture.sv */
//##########################################################################
// samples the video bus, keeps the pixel counters and builds the colour word
// feeds the pixel output stage through a capture struct
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module vidin_capture (
   input  wire logic                  tm3_clk_v0,
   input  wire logic                  rst,
   input  wire vidin_pkg::video_in_t  video,
   output vidin_pkg::capture_t        cap
);

   logic [`VIDIN_HORIZ_W-1:0] horiz;
   logic [`VIDIN_VERT_W-1:0]  vert;
   logic [`VIDIN_RGB_W-1:0]   rgb_acc;
   logic [`VIDIN_RGB_W-1:0]   rgb_word;
   logic [`VIDIN_HORIZ_W-1:0] horiz_lat;
   logic [`VIDIN_VERT_W-1:0]  vert_lat;
   logic                      field_lat;
   logic                      cref_q;

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         horiz  <= '0;
         vert   <= '0;
         cref_q <= 1'b0;
      end
      else
      begin
         cref_q <= video.cref;
         // horiz counts pixel pairs within an active line
         if (!video.href)
            horiz <= '0;
         else if (!video.cref)
            horiz <= horiz + 1'b1;
         // one line step at the end of each active line
         if (video.vs)
            vert <= '0;
         else if (!video.href && (horiz != '0))
            vert <= vert + 1'b1;
      end
   end

   // colour bits arrive split over the two cref phases
   always_ff @(posedge tm3_clk_v0)
   begin
      if (video.cref)
      begin
         rgb_acc[23:19] <= video.vpo[15:11];
         rgb_acc[18:16] <= video.vpo[7:5];
         rgb_acc[15:13] <= video.vpo[10:8];
         rgb_acc[9:8]   <= video.vpo[4:3];
         rgb_acc[2:0]   <= video.vpo[2:0];
         rgb_word       <= rgb_acc;
      end
      else
      begin
         rgb_acc[12:10] <= video.vpo[7:5];
         rgb_acc[7:3]   <= video.vpo[4:0];
         vert_lat       <= vert;
         field_lat      <= video.rts0;
         horiz_lat      <= horiz;
      end
   end

   assign cap = '{vert: vert_lat, horiz: horiz_lat, field: field_lat,
                  rgb: rgb_word, cref: cref_q};

endmodule

`default_nettype wire

/* vidin_checker.sv */
//##########################################################################
// watches the DUT outputs, decodes serial frames and compares pixels
// expected values come from the P and W lines of the stimulus file
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module vidin_checker (
   input  wire logic                     tm3_clk_v0,
   input  wire logic                     rst,
   input  wire logic                     scl,
   input  wire logic                     sda,
   input  wire logic                     new_data,
   input  wire logic [`VIDIN_PIX_W-1:0]  rgb,
   input  wire logic [`VIDIN_ADDR_W-1:0] addr,
   input  wire logic                     reg_prog_done,
   output logic                          finished,
   output int                            tests_run,
   output int                            tests_failed,
   output int                            error_count
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int NREG = `VIDIN_REG_COUNT;

   string test_name [0:5] = '{"reset_values", "frame_sequence", "prog_done",
                              "pixel_stream", "vs_clear", "reprogram"};
   bit    test_fail [0:5];
   logic [`VIDIN_ADDR_W+`VIDIN_PIX_W-1:0] exp_pix [$];
   logic [15:0] exp_wr [$];
   logic [27:0] frame_bits;
   int          nbits;
   int          frames_seen;
   int          pix_seen;
   int          done_rises;
   bit          in_frame;
   bit          reset_checked;
   logic        prev_scl;
   logic        prev_sda;
   logic        prev_done;

   task automatic mismatch(input int t, input logic [31:0] exp, input logic [31:0] act);
      $display("** Error %s: expected %h, actual %h", test_name[t], exp, act);
      test_fail[t] = 1'b1;
      error_count++;
   endtask

   task automatic problem(input int t, input string what);
      $display("%s: %s", test_name[t], what);
      test_fail[t] = 1'b1;
      error_count++;
   endtask

   task automatic close_test(input int t);
      tests_run++;
      if (test_fail[t])
      begin
         tests_failed++;
         $display("test %s failed", test_name[t]);
      end
      else
         $display("test %s passed", test_name[t]);
   endtask

   // frame bits: device byte, ack, subaddr, ack, data, ack
   // the last scl rise belongs to the stop condition
   task automatic check_frame();
      int          t;
      logic [15:0] act;
      t = (frames_seen < NREG) ? 1 : 5;
      if (nbits != 28)
         problem(t, $sformatf("frame %0d carried %0d bits instead of 27",
                              frames_seen, nbits - 1));
      else
      begin
         if (frame_bits[27:20] != `VIDIN_IIC_DEV_ADDR)
            mismatch(t, `VIDIN_IIC_DEV_ADDR, frame_bits[27:20]);
         if (frame_bits[19] || frame_bits[10] || frame_bits[1])
            problem(t, $sformatf("an ack bit of frame %0d was not driven low", frames_seen));
         act = {frame_bits[18:11], frame_bits[9:2]};
         if (exp_wr.size() != NREG)
            problem(t, $sformatf("the stimulus file does not list %0d register writes", NREG));
         else if (act != exp_wr[frames_seen % NREG])
            mismatch(t, exp_wr[frames_seen % NREG], act);
      end
      frames_seen++;
      if (frames_seen == NREG)
         close_test(1);
      else if (frames_seen == 2 * NREG)
         close_test(5);
      else if (frames_seen > 2 * NREG)
         problem(5, "more register writes than two full sequences");
   endtask

   initial
   begin
      int    fd;
      string line;
      logic [31:0] a;
      logic [31:0] d;
      finished = 1'b0;
      tests_run = 0;
      tests_failed = 0;
      error_count = 0;
      fd = $fopen("vidin_input.txt", "r");
      if (fd == 0)
         problem(0, "cannot open vidin_input.txt");
      else
      begin
         while ($fgets(line, fd) != 0)
         begin
            if (line.len() > 0 && line.getc(0) == "P" && $sscanf(line, "P %h %h", a, d) == 2)
               exp_pix.push_back({a[`VIDIN_ADDR_W-1:0], d[`VIDIN_PIX_W-1:0]});
            else if (line.len() > 0 && line.getc(0) == "W" && $sscanf(line, "W %h %h", a, d) == 2)
               exp_wr.push_back({a[7:0], d[7:0]});
         end
         $fclose(fd);
      end
   end

   always @(negedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         prev_scl  = 1'b1;
         prev_sda  = 1'b1;
         prev_done = 1'b0;
         in_frame  = 1'b0;
      end
      else
      begin
         if (!reset_checked)
         begin
            if ({scl, sda, new_data, reg_prog_done} !== 4'b1100)
               mismatch(0, 4'b1100, {scl, sda, new_data, reg_prog_done});
            reset_checked = 1'b1;
            close_test(0);
         end
         // start and stop happen with scl high, data bits on the scl rise
         if (prev_scl && scl && prev_sda && !sda)
         begin
            if (in_frame)
               problem(1, "start condition inside a frame");
            in_frame = 1'b1;
            nbits    = 0;
         end
         else if (prev_scl && scl && !prev_sda && sda && in_frame)
         begin
            check_frame();
            in_frame = 1'b0;
         end
         else if (in_frame && !prev_scl && scl)
         begin
            frame_bits = {frame_bits[26:0], sda};
            nbits++;
         end
         prev_scl = scl;
         prev_sda = sda;
         if (reg_prog_done && !prev_done)
         begin
            done_rises++;
            if (done_rises == 1)
            begin
               if (frames_seen != NREG)
                  mismatch(2, NREG, frames_seen);
               close_test(2);
            end
         end
         prev_done = reg_prog_done;
         if (new_data)
         begin
            if (pix_seen < exp_pix.size())
            begin
               if ({addr, rgb} !== exp_pix[pix_seen])
                  mismatch(3, exp_pix[pix_seen], {addr, rgb});
               if (pix_seen == 0)
               begin
                  // first line after vs sits on line zero
                  if (addr[`VIDIN_ADDR_W-1:`VIDIN_HORIZ_W-1] !== '0)
                     mismatch(4, 0, addr[`VIDIN_ADDR_W-1:`VIDIN_HORIZ_W-1]);
                  close_test(4);
               end
               pix_seen++;
               if (pix_seen == exp_pix.size())
                  close_test(3);
            end
            else
               problem(3, $sformatf("unexpected pixel at address %h", addr));
         end
         finished = reset_checked && (frames_seen >= 2 * NREG) && (done_rises >= 2)
                    && (pix_seen >= exp_pix.size());
      end
   end

endmodule

`default_nettype wire

/* vidin_input.txt */
# S vs href cref rts0 vpo count : cref 2 = count pixel pairs (cref high, low), else count cycles
# P addr rgb : expected pixel in order    W subaddr data : expected decoder write in order
S 1 0 1 0 0000 4
S 0 0 1 0 0000 4
S 0 1 2 0 00A5 4
S 0 0 1 0 0000 3
S 0 1 2 0 1234 6
S 0 0 1 0 0000 4700
S 0 1 2 1 0000 4
S 0 0 1 0 0000 3
S 0 1 2 0 00FF 2
S 0 0 1 0 0000 8
P 00000 2D
P 00001 2D
P 00200 A4
P 00201 A4
P 00202 A4
P 00600 FF
W 02 C0
W 03 23
W 06 EB
W 07 E0
W 08 80
W 09 01
W 0A 80
W 0B 47
W 0C 40
W 0E 01
W 10 00
W 11 1C
W 12 09

/* vidin_params.svh */
//##########################################################################
// fixed widths and constants of the video front end and the decoder chip
// include before any module or package that needs them
//##########################################################################

`ifndef VIDIN_PARAMS_SVH
`define VIDIN_PARAMS_SVH

// video bus and capture widths
`define VIDIN_VPO_W 16
`define VIDIN_HORIZ_W 10
`define VIDIN_VERT_W 8
`define VIDIN_RGB_W 24

// output pixel and frame buffer address
`define VIDIN_PIX_W 8
`define VIDIN_ADDR_W 19

// write address byte of the video decoder
`define VIDIN_IIC_DEV_ADDR 8'h48

// clock cycles per serial step
`define VIDIN_IIC_DIV 4

// writes in the decoder setup table
`define VIDIN_REG_COUNT 13

`endif

/* vidin_pixel_out.sv */
//##########################################################################
// emits one pixel per falling cref for even pixels of the even field
// new_data pulses for one cycle with the pixel and its buffer address
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module vidin_pixel_out (
   input  wire logic                 tm3_clk_v0,
   input  wire logic                 rst,
   input  wire vidin_pkg::capture_t  cap,
   output vidin_pkg::pixel_t         pixel,
   output logic                      new_data
);

   logic cref_d1;
   logic cref_d2;
   logic emit;

   // falling cref, gated by field and the pixel parity
   assign emit = !cref_d1 && cref_d2 && !cap.field && !cap.horiz[0];

   always_ff @(posedge tm3_clk_v0)
   begin
      if (!rst)
      begin
         cref_d1  <= 1'b0;
         cref_d2  <= 1'b0;
         new_data <= 1'b0;
      end
      else
      begin
         cref_d1  <= cap.cref;
         cref_d2  <= cref_d1;
         new_data <= emit;
      end
   end

   // address is line then pixel pair, zero extended
   always_ff @(posedge tm3_clk_v0)
   begin
      if (emit)
      begin
         pixel.addr <= {{(`VIDIN_ADDR_W - `VIDIN_VERT_W - `VIDIN_HORIZ_W + 1){1'b0}},
                        cap.vert, cap.horiz[`VIDIN_HORIZ_W-1:1]};
         pixel.rgb  <= cap.rgb[`VIDIN_PIX_W-1:0];
      end
   end

endmodule

`default_nettype wire

/* vidin_pkg.sv */
//##########################################################################
// shared types of the video front end
// structs carry the video bus, capture state, pixels and register writes
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

package vidin_pkg;

   // one sample of the video input bus
   typedef struct packed {
      logic                    vs;
      logic                    href;
      logic                    cref;
      logic                    rts0;
      logic [`VIDIN_VPO_W-1:0] vpo;
   } video_in_t;

   // one pixel towards the frame buffer
   typedef struct packed {
      logic [`VIDIN_ADDR_W-1:0] addr;
      logic [`VIDIN_PIX_W-1:0]  rgb;
   } pixel_t;

   // one decoder register write
   typedef struct packed {
      logic [7:0] subaddr;
      logic [7:0] data;
   } iic_write_t;

   // latched position, field and colour word, plus the registered cref phase
   typedef struct packed {
      logic [`VIDIN_VERT_W-1:0]  vert;
      logic [`VIDIN_HORIZ_W-1:0] horiz;
      logic                      field;
      logic [`VIDIN_RGB_W-1:0]   rgb;
      logic                      cref;
   } capture_t;

   typedef enum logic [1:0] {
      PROG_START,
      PROG_WAIT,
      PROG_NEXT,
      PROG_DONE
   } prog_state_e;

   typedef enum logic [1:0] {
      IIC_IDLE,
      IIC_START,
      IIC_BIT,
      IIC_STOP
   } iic_phase_e;

endpackage

`default_nettype wire

/* vidin_props.sv */
//##########################################################################
// concurrent assertions on the serial wire pair and the pixel strobe
// bound into the serializer and the pixel output stage
//##########################################################################

`default_nettype none

module vidin_props (
   input wire logic                  tm3_clk_v0,
   input wire logic                  rst,
   input wire logic                  scl,
   input wire logic                  sda,
   input wire logic                  busy,
   input wire logic                  new_data,
   input wire vidin_pkg::iic_phase_e phase
);

   timeunit 1ns;
   timeprecision 100ps;

   // data moves only with scl low, start and stop excepted
   sda_stable: assert property (@(posedge tm3_clk_v0) disable iff (!rst)
      (scl && $past(scl) && (sda != $past(sda))) |->
      ((phase == vidin_pkg::IIC_START) || (phase == vidin_pkg::IIC_STOP)))
      else $error("sda changed while scl was high outside start or stop");

   strobe_single: assert property (@(posedge tm3_clk_v0) disable iff (!rst)
      new_data |=> !new_data)
      else $error("new_data held high for two cycles");

   idle_after_reset: assert property (@(posedge tm3_clk_v0) !rst |=> !busy)
      else $error("serializer busy right after reset");

endmodule

bind iic_write_serializer vidin_props u_iic_props (
   .tm3_clk_v0 (tm3_clk_v0),
   .rst        (rst),
   .scl        (scl),
   .sda        (sda),
   .busy       (busy),
   .new_data   (1'b0),
   .phase      (phase)
);

bind vidin_pixel_out vidin_props u_pix_props (
   .tm3_clk_v0 (tm3_clk_v0),
   .rst        (rst),
   .scl        (1'b1),
   .sda        (1'b1),
   .busy       (1'b0),
   .new_data   (new_data),
   .phase      (vidin_pkg::IIC_IDLE)
);

`default_nettype wire

/* vidin_top.sv */
//##########################################################################
// video capture front end, top level
// joins the pixel path and the decoder programming path
//##########################################################################

`include "vidin_params.svh"

`default_nettype none

module vidin_top (
   input  wire logic                     tm3_clk_v0,
   input  wire logic                     rst,
   input  wire logic                     tm3_vidin_vs,
   input  wire logic                     tm3_vidin_href,
   input  wire logic                     tm3_vidin_cref,
   input  wire logic                     tm3_vidin_rts0,
   input  wire logic [`VIDIN_VPO_W-1:0]  tm3_vidin_vpo,
   output logic                          tm3_vidin_sda,
   output logic                          tm3_vidin_scl,
   output logic                          vidin_new_data,
   output logic [`VIDIN_PIX_W-1:0]       vidin_rgb_reg,
   output logic [`VIDIN_ADDR_W-1:0]      vidin_addr_reg,
   output logic                          reg_prog_done
);

   vidin_pkg::video_in_t  video;
   vidin_pkg::capture_t   cap;
   vidin_pkg::pixel_t     pixel;
   vidin_pkg::iic_write_t wr;
   logic                  iic_start;
   logic                  iic_busy;

   assign video = '{vs: tm3_vidin_vs, href: tm3_vidin_href, cref: tm3_vidin_cref,
                    rts0: tm3_vidin_rts0, vpo: tm3_vidin_vpo};

   vidin_capture u_capture (
      .tm3_clk_v0 (tm3_clk_v0),
      .rst        (rst),
      .video      (video),
      .cap        (cap)
   );

   vidin_pixel_out u_pixel_out (
      .tm3_clk_v0 (tm3_clk_v0),
      .rst        (rst),
      .cap        (cap),
      .pixel      (pixel),
      .new_data   (vidin_new_data)
   );

   assign vidin_rgb_reg  = pixel.rgb;
   assign vidin_addr_reg = pixel.addr;

   decoder_reg_program u_reg_program (
      .tm3_clk_v0 (tm3_clk_v0),
      .rst        (rst),
      .rts0       (tm3_vidin_rts0),
      .busy       (iic_busy),
      .wr         (wr),
      .start      (iic_start),
      .done       (reg_prog_done)
   );

   iic_write_serializer u_serializer (
      .tm3_clk_v0 (tm3_clk_v0),
      .rst        (rst),
      .wr         (wr),
      .start      (iic_start),
      .busy       (iic_busy),
      .scl        (tm3_vidin_scl),
      .sda        (tm3_vidin_sda)
   );

endmodule

`default_nettype wire
